// ==== design/aluShifter.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module aluShifter (
   input  logic CLOCK,
   input  logic rstN,
   input  cpuPkg::phase_t phase,
   input  cpuPkg::aluOp_t op,
   input  logic [`WORD_W-1:0] a,
   input  logic [`WORD_W-1:0] b,
   input  logic [3:0] shamt,
   output logic [`WORD_W-1:0] result,
   output cpuPkg::flags_t flags
);

   // b is the destination side, so SUB gives b - a
   logic [`WORD_W:0] sum;
   logic [`WORD_W:0] diff;
   logic [`WORD_W:0] shiftLeft;
   logic [`WORD_W:0] shiftRight;
   logic signed [`WORD_W:0] shiftArith;
   logic [`WORD_W-1:0] rotated;
   logic carry;
   logic overflow;
   logic setsFlags;

   assign sum = {1'b0, b} + {1'b0, a};
   assign diff = {1'b0, b} - {1'b0, a}; // Top bit is the borrow
   assign shiftLeft = {1'b0, b} << shamt;
   assign shiftRight = {b, 1'b0} >> shamt;
   assign shiftArith = $signed({b, 1'b0}) >>> shamt;
   assign rotated = (b << shamt) | (b >> (`WORD_W - shamt));

   always_comb begin
      carry = 1'b0;
      overflow = 1'b0;
      case (op)
         cpuPkg::OP_ADD: begin
            result = sum[`WORD_W-1:0];
            carry = sum[`WORD_W];
            overflow = (a[`WORD_W-1] == b[`WORD_W-1]) &&
                       (result[`WORD_W-1] != b[`WORD_W-1]);
         end
         cpuPkg::OP_SUB, cpuPkg::OP_CMP: begin
            result = diff[`WORD_W-1:0];
            carry = diff[`WORD_W];
            overflow = (a[`WORD_W-1] != b[`WORD_W-1]) &&
                       (result[`WORD_W-1] != b[`WORD_W-1]);
         end
         cpuPkg::OP_AND: result = b & a;
         cpuPkg::OP_OR:  result = b | a;
         cpuPkg::OP_XOR: result = b ^ a;
         cpuPkg::OP_MOV: result = a;
         cpuPkg::OP_SLL: begin
            result = shiftLeft[`WORD_W-1:0];
            carry = shiftLeft[`WORD_W];
         end
         cpuPkg::OP_SLR: begin
            result = rotated;
            carry = (shamt != 4'd0) && rotated[0]; // Last bit wrapped around
         end
         cpuPkg::OP_SRL: begin
            result = shiftRight[`WORD_W:1];
            carry = shiftRight[0];
         end
         cpuPkg::OP_SRA: begin
            result = shiftArith[`WORD_W:1];
            carry = shiftArith[0];
         end
         default: result = sum[`WORD_W-1:0]; // Address and LI path
      endcase
   end

   assign setsFlags = op inside {cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
                                 cpuPkg::OP_OR, cpuPkg::OP_XOR, cpuPkg::OP_CMP,
                                 cpuPkg::OP_SLL, cpuPkg::OP_SLR, cpuPkg::OP_SRL,
                                 cpuPkg::OP_SRA};

   always_ff @(posedge CLOCK) begin
      if (!rstN)
         flags <= '0;
      else if (phase == cpuPkg::PH_EXEC && setsFlags) begin
         flags.s <= result[`WORD_W-1];
         flags.z <= (result == '0);
         flags.c <= carry;
         flags.v <= overflow;
      end
   end

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module controlUnit (
   input  logic CLOCK,
   input  logic rstN,
   input  cpuPkg::phase_t phase,
   input  logic [`WORD_W-1:0] instr,
   output cpuPkg::ctrlWord_t ctrl
);

   localparam cpuPkg::ctrlWord_t ctrlNop = '{
      aluOp: cpuPkg::OP_NONE,
      branch: cpuPkg::BR_NONE,
      default: '0
   };

   cpuPkg::ctrlWord_t decoded;

   always_comb begin
      decoded = ctrlNop;
      decoded.aSel = 1'b1;
      decoded.srcReg = instr[13:11];
      decoded.dstReg = instr[10:8];
      decoded.imm = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
      case (instr[15:14])
         2'b00: begin // LD ra,d(rb)
            decoded.srcReg = instr[10:8]; // Base
            decoded.dstReg = instr[13:11];
            decoded.bSel = 1'b1;
            decoded.addrSel = 1'b1;
            decoded.loadSel = 1'b1;
            decoded.regWrite = 1'b1;
         end
         2'b01: begin // ST ra,d(rb)
            decoded.srcReg = instr[10:8];
            decoded.dstReg = instr[13:11]; // Store data read on port B
            decoded.bSel = 1'b1;
            decoded.addrSel = 1'b1;
            decoded.memWrite = 1'b1;
         end
         2'b10: begin
            case (instr[13:11])
               3'b000: begin // LI rb,d
                  decoded.aSel = 1'b0;
                  decoded.bSel = 1'b1;
                  decoded.regWrite = 1'b1;
               end
               3'b100: decoded.branch = cpuPkg::BR_ALWAYS;
               3'b111: begin
                  case (instr[10:8])
                     3'b000: decoded.branch = cpuPkg::BR_EQ;
                     3'b001: decoded.branch = cpuPkg::BR_LT;
                     3'b010: decoded.branch = cpuPkg::BR_LE;
                     3'b011: decoded.branch = cpuPkg::BR_NE;
                     default: ;
                  endcase
               end
               default: ;
            endcase
         end
         default: begin // Compute class
            case (instr[7:4])
               4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b0100, 4'b0110,
               4'b1000, 4'b1001, 4'b1010, 4'b1011: begin
                  decoded.aluOp = cpuPkg::aluOp_t'(instr[7:4]);
                  decoded.regWrite = 1'b1;
               end
               4'b0101: decoded.aluOp = cpuPkg::OP_CMP; // Flags only
               4'b1100: begin
                  decoded.aluOp = cpuPkg::OP_IN;
                  decoded.inputSel = 1'b1;
                  decoded.regWrite = 1'b1;
               end
               4'b1101: begin
                  decoded.aluOp = cpuPkg::OP_OUT;
                  decoded.outStrobe = 1'b1;
               end
               4'b1111: decoded.halt = 1'b1;
               default: ;
            endcase
         end
      endcase
   end

   // Control word held from decode through writeback
   always_ff @(posedge CLOCK) begin
      if (!rstN)
         ctrl <= ctrlNop;
      else if (phase == cpuPkg::PH_DECODE)
         ctrl <= decoded;
   end

   noWriteClash: assert property (@(posedge CLOCK) disable iff (!rstN)
      !(ctrl.regWrite && ctrl.memWrite));

endmodule

// ==== design/cpuPkg.sv ====
`include "cpu_params.svh"

package cpuPkg;

   typedef enum logic [2:0] {
      PH_IDLE,
      PH_FETCH,
      PH_DECODE,
      PH_EXEC,
      PH_MEM,
      PH_WB
   } phase_t;

   // Values follow the compute opcode field, HLT goes through the halt bit
   typedef enum logic [3:0] {
      OP_ADD  = 4'b0000,
      OP_SUB  = 4'b0001,
      OP_AND  = 4'b0010,
      OP_OR   = 4'b0011,
      OP_XOR  = 4'b0100,
      OP_CMP  = 4'b0101,
      OP_MOV  = 4'b0110,
      OP_SLL  = 4'b1000,
      OP_SLR  = 4'b1001, // Rotate left
      OP_SRL  = 4'b1010,
      OP_SRA  = 4'b1011,
      OP_IN   = 4'b1100,
      OP_OUT  = 4'b1101,
      OP_NONE = 4'b1111  // Not a compute op, ALU adds a and b
   } aluOp_t;

   typedef enum logic [2:0] {
      BR_NONE,
      BR_ALWAYS,
      BR_EQ,
      BR_LT,
      BR_LE,
      BR_NE
   } branch_t;

   typedef struct packed {
      logic s;
      logic z;
      logic c;
      logic v;
   } flags_t;

   typedef struct packed {
      logic regWrite;
      logic memWrite;
      logic outStrobe;
      logic halt;
      logic aSel;     // A operand from register, else zero for LI
      logic bSel;     // B operand from immediate, else register
      logic inputSel; // inData into the register file
      logic addrSel;  // Data address from the ALU
      logic loadSel;  // Memory data into the register file
      aluOp_t aluOp;
      branch_t branch;
      logic [`REG_ADDR_W-1:0] srcReg;
      logic [`REG_ADDR_W-1:0] dstReg;
      logic [`WORD_W-1:0] imm;
   } ctrlWord_t;

   typedef struct packed {
      logic we;
      logic [`ADDR_W-1:0] addr;
      logic [`WORD_W-1:0] data;
   } loadPort_t;

endpackage

// ==== design/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path and instruction width
`define WORD_W 16

// Unified program and data memory
`define MEM_DEPTH 256
`define ADDR_W 8

// General purpose registers
`define REG_COUNT 8
`define REG_ADDR_W 3

// Cycles per instruction, fetch through writeback
`define PHASE_COUNT 5

`endif

// ==== design/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer (
   input  logic CLOCK,
   input  logic rstN,
   input  logic exec,
   input  logic halt,
   output cpuPkg::phase_t phase,
   output logic startPulse
);

   cpuPkg::phase_t nextPhase;

   assign startPulse = (phase == cpuPkg::PH_IDLE) && exec; // Clears the PC

   always_comb begin
      case (phase)
         cpuPkg::PH_IDLE:   nextPhase = exec ? cpuPkg::PH_FETCH : cpuPkg::PH_IDLE;
         cpuPkg::PH_FETCH:  nextPhase = cpuPkg::PH_DECODE;
         cpuPkg::PH_DECODE: nextPhase = cpuPkg::PH_EXEC;
         cpuPkg::PH_EXEC:   nextPhase = cpuPkg::PH_MEM;
         cpuPkg::PH_MEM:    nextPhase = cpuPkg::PH_WB;
         cpuPkg::PH_WB:     nextPhase = halt ? cpuPkg::PH_IDLE : cpuPkg::PH_FETCH;
         default:           nextPhase = cpuPkg::PH_IDLE;
      endcase
   end

   always_ff @(posedge CLOCK) begin
      if (!rstN)
         phase <= cpuPkg::PH_IDLE;
      else
         phase <= nextPhase;
   end

   idleHolds: assert property (@(posedge CLOCK) disable iff (!rstN)
      (phase == cpuPkg::PH_IDLE && !exec) |=> phase == cpuPkg::PH_IDLE);

endmodule

// ==== design/programCounter.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module programCounter (
   input  logic CLOCK,
   input  logic rstN,
   input  cpuPkg::phase_t phase,
   input  logic startPulse,
   input  cpuPkg::branch_t branch,
   input  logic [`WORD_W-1:0] imm,
   input  cpuPkg::flags_t flags,
   output logic [`ADDR_W-1:0] pc
);

   logic taken;

   // Condition from the flags left by the last compute op
   always_comb begin
      case (branch)
         cpuPkg::BR_ALWAYS: taken = 1'b1;
         cpuPkg::BR_EQ:     taken = flags.z;
         cpuPkg::BR_LT:     taken = flags.s ^ flags.v;
         cpuPkg::BR_LE:     taken = flags.z | (flags.s ^ flags.v);
         cpuPkg::BR_NE:     taken = !flags.z;
         default:           taken = 1'b0;
      endcase
   end

   always_ff @(posedge CLOCK) begin
      if (!rstN || startPulse)
         pc <= '0;
      else if (phase == cpuPkg::PH_WB) begin
         if (taken)
            pc <= pc + `ADDR_W'd1 + imm[`ADDR_W-1:0]; // Wraps within memory
         else
            pc <= pc + `ADDR_W'd1;
      end
   end

endmodule

// ==== design/registerFile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module registerFile (
   input  logic CLOCK,
   input  logic rstN,
   input  logic [`REG_ADDR_W-1:0] readA,
   input  logic [`REG_ADDR_W-1:0] readB,
   output logic [`WORD_W-1:0] dataA,
   output logic [`WORD_W-1:0] dataB,
   input  logic writeEn,
   input  logic [`REG_ADDR_W-1:0] writeAddr,
   input  logic [`WORD_W-1:0] writeData
);

   logic [`WORD_W-1:0] regs [`REG_COUNT];

   // Two asynchronous read ports
   assign dataA = regs[readA];
   assign dataB = regs[readB];

   always_ff @(posedge CLOCK) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end
      else if (writeEn)
         regs[writeAddr] <= writeData;
   end

endmodule

// ==== design/simpleCpu.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module simpleCpu (
   input  logic CLOCK,
   input  logic rstN,
   input  logic exec,
   input  logic [`WORD_W-1:0] inData,
   input  cpuPkg::loadPort_t progLoad,
   output logic [`WORD_W-1:0] outData,
   output logic outValid,
   output logic halted,
   output cpuPkg::flags_t flags,
   output cpuPkg::phase_t phase
);

   cpuPkg::ctrlWord_t ctrl;
   logic startPulse;
   logic [`ADDR_W-1:0] pc;
   logic [`ADDR_W-1:0] memAddr;
   logic [`WORD_W-1:0] instrReg;
   logic [`WORD_W-1:0] memData;
   logic [`WORD_W-1:0] dataA;
   logic [`WORD_W-1:0] dataB;
   logic [`WORD_W-1:0] aluA;
   logic [`WORD_W-1:0] aluB;
   logic [`WORD_W-1:0] aluResult;
   logic [`WORD_W-1:0] regWriteData;
   logic regWriteEn;

   phaseSequencer phaseSequencer_inst (.CLOCK, .rstN, .exec, .halt(ctrl.halt), .phase,
                                       .startPulse);

   programCounter programCounter_inst (.CLOCK, .rstN, .phase, .startPulse,
                                       .branch(ctrl.branch), .imm(ctrl.imm), .flags, .pc);

   controlUnit controlUnit_inst (.CLOCK, .rstN, .phase, .instr(instrReg), .ctrl);

   registerFile registerFile_inst (.CLOCK, .rstN, .readA(ctrl.srcReg), .readB(ctrl.dstReg),
                                   .dataA, .dataB, .writeEn(regWriteEn),
                                   .writeAddr(ctrl.dstReg), .writeData(regWriteData));

   assign aluA = ctrl.aSel ? dataA : '0;
   assign aluB = ctrl.bSel ? ctrl.imm : dataB;

   aluShifter aluShifter_inst (.CLOCK, .rstN, .phase, .op(ctrl.aluOp), .a(aluA), .b(aluB),
                               .shamt(ctrl.imm[3:0]), .result(aluResult), .flags);

   // Fetch uses the PC, the stale control word is still present then
   assign memAddr = (ctrl.addrSel && phase != cpuPkg::PH_FETCH) ?
                    aluResult[`ADDR_W-1:0] : pc;

   unifiedMemory unifiedMemory_inst (.CLOCK, .phase, .progLoad, .addr(memAddr),
                                     .writeEn(ctrl.memWrite), .writeData(dataB),
                                     .readData(memData));

   always_ff @(posedge CLOCK) begin
      if (phase == cpuPkg::PH_FETCH)
         instrReg <= memData;
   end

   always_comb begin
      if (ctrl.loadSel)
         regWriteData = memData;
      else if (ctrl.inputSel)
         regWriteData = inData;
      else
         regWriteData = aluResult;
   end

   assign regWriteEn = ctrl.regWrite && (phase == cpuPkg::PH_WB);
   assign halted = (phase == cpuPkg::PH_IDLE);

   // OUT captured at the end of PH_MEM so the strobe sits in writeback
   always_ff @(posedge CLOCK) begin
      if (!rstN)
         outValid <= 1'b0;
      else
         outValid <= (phase == cpuPkg::PH_MEM) && ctrl.outStrobe;
   end

   always_ff @(posedge CLOCK) begin
      if (phase == cpuPkg::PH_MEM && ctrl.outStrobe)
         outData <= dataA; // rs
   end

   outInWb: assert property (@(posedge CLOCK) disable iff (!rstN)
      outValid |-> phase == cpuPkg::PH_WB);

endmodule

// ==== design/unifiedMemory.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module unifiedMemory (
   input  logic CLOCK,
   input  cpuPkg::phase_t phase,
   input  cpuPkg::loadPort_t progLoad,
   input  logic [`ADDR_W-1:0] addr,
   input  logic writeEn,
   input  logic [`WORD_W-1:0] writeData,
   output logic [`WORD_W-1:0] readData
);

   logic [`WORD_W-1:0] mem [`MEM_DEPTH];

   assign readData = mem[addr];

   // Loader owns the array only while the core is idle
   always_ff @(posedge CLOCK) begin
      if (phase == cpuPkg::PH_IDLE) begin
         if (progLoad.we)
            mem[progLoad.addr] <= progLoad.data;
      end
      else if (phase == cpuPkg::PH_MEM && writeEn)
         mem[addr] <= writeData;
   end

endmodule

// ==== dv/simpleCpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module simpleCpuTb;

   typedef enum logic [1:0] {
      KIND_ALU,
      KIND_SHIFT,
      KIND_MEMIO,
      KIND_BRANCH
   } rowKind_t;

   typedef struct packed {
      rowKind_t kind;
      logic [3:0] sel;      // Compute op, or branch condition
      logic [7:0] opA;      // r1, shift amount for shifts
      logic [7:0] opB;      // r2
      logic [`WORD_W-1:0] inVal;
      logic rerun;          // Second exec without reloading
      logic expOut;
      logic [`WORD_W-1:0] expData;
      cpuPkg::flags_t expFlags;
   } caseRow_t;

   localparam int NUM_ROWS = 27;
   localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 * 5 + 200;
   localparam logic [7:0] MARKER = 8'h5A;
   localparam logic [15:0] HLT = 16'hC0F0;

   // Branch conditions, B takes the spare code
   localparam logic [3:0] COND_EQ = 4'd0;
   localparam logic [3:0] COND_LT = 4'd1;
   localparam logic [3:0] COND_LE = 4'd2;
   localparam logic [3:0] COND_NE = 4'd3;
   localparam logic [3:0] COND_ALWAYS = 4'd4;

   logic CLOCK = 1'b0;
   logic rstN;
   logic exec;
   logic [`WORD_W-1:0] inData;
   cpuPkg::loadPort_t progLoad;
   logic [`WORD_W-1:0] outData;
   logic outValid;
   logic halted;
   cpuPkg::flags_t flags;
   cpuPkg::phase_t phase;

   caseRow_t rows [NUM_ROWS];
   logic [`WORD_W-1:0] prog [$];
   logic [`WORD_W-1:0] seen [$];
   cpuPkg::flags_t modelFlags;
   int mismatchCount = 0;
   int failCount = 0;
   int cycles = 0;
   integer seed = 32'h12e;

   simpleCpu simpleCpu_inst (.CLOCK, .rstN, .exec, .inData, .progLoad, .outData, .outValid,
                             .halted, .flags, .phase);

   always #10 CLOCK = ~CLOCK;

   always @(posedge CLOCK) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   function automatic logic [15:0] sext(input logic [7:0] x);
      return {{8{x[7]}}, x};
   endfunction

   function automatic logic [15:0] li(input int rb, input logic [7:0] d);
      return {2'b10, 3'b000, 3'(rb), d};
   endfunction

   function automatic logic [15:0] compute(input int rs, input int rd, input logic [3:0] op,
                                           input logic [3:0] d);
      return {2'b11, 3'(rs), 3'(rd), op, d};
   endfunction

   function automatic logic [15:0] memOp(input logic [1:0] cls, input int ra, input int rb,
                                         input logic [7:0] d);
      return {cls, 3'(ra), 3'(rb), d};
   endfunction

   function automatic caseRow_t makeRow(input rowKind_t kind, input logic [3:0] sel,
                                        input logic [7:0] opA, input logic [7:0] opB,
                                        input logic useRandom, input logic rerun);
      caseRow_t r;
      r = '0;
      r.kind = kind;
      r.sel = sel;
      r.opA = useRandom ? 8'($random(seed)) : opA;
      r.opB = useRandom ? 8'($random(seed)) : opB;
      r.inVal = {r.opA, r.opB}; // Only IN programs read it
      r.rerun = rerun;
      return r;
   endfunction

   // Expected output and flags, flags carry over from row to row
   function automatic caseRow_t modelRow(input caseRow_t r);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] res;
      logic [15:0] outVal;
      logic [3:0] op;
      logic c;
      logic v;
      logic setFlags;
      int wide;
      a = sext(r.opA);
      b = sext(r.opB);
      res = b;
      c = 1'b0;
      v = 1'b0;
      setFlags = 1'b1;
      r.expOut = 1'b1;
      op = (r.kind == KIND_BRANCH) ? cpuPkg::OP_CMP : r.sel;
      case (r.kind)
         KIND_ALU, KIND_BRANCH: begin
            case (op)
               cpuPkg::OP_ADD: begin
                  res = b + a;
                  c = (int'(b) + int'(a)) > 65535;
                  wide = int'($signed(b)) + int'($signed(a));
                  v = (wide > 32767) || (wide < -32768);
               end
               cpuPkg::OP_SUB, cpuPkg::OP_CMP: begin
                  res = b - a;
                  c = b < a; // Borrow
                  wide = int'($signed(b)) - int'($signed(a));
                  v = (wide > 32767) || (wide < -32768);
               end
               cpuPkg::OP_AND: res = b & a;
               cpuPkg::OP_OR:  res = b | a;
               cpuPkg::OP_XOR: res = b ^ a;
               default: begin // MOV leaves the flags alone
                  res = a;
                  setFlags = 1'b0;
               end
            endcase
            outVal = (op == cpuPkg::OP_CMP) ? b : res;
         end
         KIND_SHIFT: begin
            // One bit per step, C keeps the last bit pushed out
            for (int i = 0; i < int'(r.opA[3:0]); i++) begin
               c = (op == cpuPkg::OP_SLL || op == cpuPkg::OP_SLR) ? res[15] : res[0];
               case (op)
                  cpuPkg::OP_SLL: res = {res[14:0], 1'b0};
                  cpuPkg::OP_SLR: res = {res[14:0], res[15]};
                  cpuPkg::OP_SRL: res = {1'b0, res[15:1]};
                  default:        res = {res[15], res[15:1]};
               endcase
            end
            outVal = res;
         end
         default: begin // Input stored and loaded back
            outVal = r.inVal;
            setFlags = 1'b0;
         end
      endcase
      if (setFlags)
         modelFlags = '{s: res[15], z: (res == 16'h0), c: c, v: v};
      if (r.kind == KIND_BRANCH) begin
         case (r.sel)
            COND_EQ: r.expOut = modelFlags.z;
            COND_LT: r.expOut = modelFlags.s ^ modelFlags.v;
            COND_LE: r.expOut = modelFlags.z | (modelFlags.s ^ modelFlags.v);
            COND_NE: r.expOut = !modelFlags.z;
            default: r.expOut = 1'b1;
         endcase
         outVal = sext(MARKER);
      end
      r.expData = outVal;
      r.expFlags = modelFlags;
      return r;
   endfunction

   task automatic fillTable();
      rows[0]  = makeRow(KIND_ALU, cpuPkg::OP_ADD, 8'h05, 8'h03, 1'b0, 1'b0);
      rows[1]  = makeRow(KIND_ALU, cpuPkg::OP_ADD, 8'hFF, 8'h01, 1'b0, 1'b0); // Carry, zero
      rows[2]  = makeRow(KIND_ALU, cpuPkg::OP_SUB, 8'h03, 8'h05, 1'b0, 1'b0);
      rows[3]  = makeRow(KIND_ALU, cpuPkg::OP_SUB, 8'h05, 8'h03, 1'b0, 1'b0); // Borrow
      rows[4]  = makeRow(KIND_ALU, cpuPkg::OP_AND, 8'h00, 8'h00, 1'b1, 1'b0);
      rows[5]  = makeRow(KIND_ALU, cpuPkg::OP_OR, 8'h00, 8'h00, 1'b1, 1'b0);
      rows[6]  = makeRow(KIND_ALU, cpuPkg::OP_XOR, 8'h00, 8'h00, 1'b1, 1'b0);
      rows[7]  = makeRow(KIND_ALU, cpuPkg::OP_XOR, 8'h5A, 8'h5A, 1'b0, 1'b0);
      rows[8]  = makeRow(KIND_ALU, cpuPkg::OP_MOV, 8'h80, 8'h12, 1'b0, 1'b1);
      rows[9]  = makeRow(KIND_ALU, cpuPkg::OP_CMP, 8'h44, 8'h44, 1'b0, 1'b0);
      rows[10] = makeRow(KIND_ALU, cpuPkg::OP_CMP, 8'h10, 8'h20, 1'b0, 1'b1);
      rows[11] = makeRow(KIND_SHIFT, cpuPkg::OP_SLL, 8'h04, 8'h81, 1'b0, 1'b0);
      rows[12] = makeRow(KIND_SHIFT, cpuPkg::OP_SLR, 8'h03, 8'h96, 1'b0, 1'b0);
      rows[13] = makeRow(KIND_SHIFT, cpuPkg::OP_SRL, 8'h01, 8'h03, 1'b0, 1'b0);
      rows[14] = makeRow(KIND_SHIFT, cpuPkg::OP_SRA, 8'h07, 8'h80, 1'b0, 1'b0);
      rows[15] = makeRow(KIND_SHIFT, cpuPkg::OP_SRL, 8'h00, 8'h00, 1'b1, 1'b0);
      rows[16] = makeRow(KIND_SHIFT, cpuPkg::OP_SLR, 8'h00, 8'hF0, 1'b0, 1'b0); // No shift
      rows[17] = makeRow(KIND_MEMIO, 4'd0, 8'hBE, 8'hEF, 1'b0, 1'b1);
      rows[18] = makeRow(KIND_BRANCH, COND_EQ, 8'h07, 8'h07, 1'b0, 1'b0);
      rows[19] = makeRow(KIND_BRANCH, COND_EQ, 8'h07, 8'h08, 1'b0, 1'b0);
      rows[20] = makeRow(KIND_BRANCH, COND_LT, 8'h05, 8'h01, 1'b0, 1'b0);
      rows[21] = makeRow(KIND_BRANCH, COND_LT, 8'h01, 8'h05, 1'b0, 1'b0);
      rows[22] = makeRow(KIND_BRANCH, COND_LE, 8'h09, 8'h09, 1'b0, 1'b0);
      rows[23] = makeRow(KIND_BRANCH, COND_NE, 8'h03, 8'h03, 1'b0, 1'b0);
      rows[24] = makeRow(KIND_BRANCH, COND_NE, 8'h00, 8'h00, 1'b1, 1'b0);
      rows[25] = makeRow(KIND_BRANCH, COND_ALWAYS, 8'h00, 8'h00, 1'b0, 1'b0);
      rows[26] = makeRow(KIND_BRANCH, COND_LE, 8'h00, 8'h00, 1'b1, 1'b0);
   endtask

   task automatic buildProgram(input caseRow_t r);
      prog = {};
      case (r.kind)
         KIND_ALU: begin
            prog.push_back(li(1, r.opA));
            prog.push_back(li(2, r.opB));
            prog.push_back(compute(1, 2, r.sel, 4'd0)); // op r2,r1
            prog.push_back(compute(2, 0, cpuPkg::OP_OUT, 4'd0));
         end
         KIND_SHIFT: begin
            prog.push_back(li(2, r.opB));
            prog.push_back(compute(0, 2, r.sel, r.opA[3:0]));
            prog.push_back(compute(2, 0, cpuPkg::OP_OUT, 4'd0));
         end
         KIND_MEMIO: begin
            prog.push_back(compute(0, 3, cpuPkg::OP_IN, 4'd0));
            prog.push_back(memOp(2'b01, 3, 0, 8'd5)); // ST r3,5(r0)
            prog.push_back(memOp(2'b00, 4, 0, 8'd5)); // LD r4,5(r0)
            prog.push_back(compute(4, 0, cpuPkg::OP_OUT, 4'd0));
         end
         default: begin
            prog.push_back(li(1, r.opA));
            prog.push_back(li(2, r.opB));
            prog.push_back(li(5, MARKER));
            prog.push_back(compute(1, 2, cpuPkg::OP_CMP, 4'd0));
            if (r.sel == COND_ALWAYS)
               prog.push_back({2'b10, 3'b100, 3'b000, 8'd1});
            else
               prog.push_back({2'b10, 3'b111, r.sel[2:0], 8'd1});
            prog.push_back(HLT); // Reached when the branch falls through
            prog.push_back(compute(5, 0, cpuPkg::OP_OUT, 4'd0));
         end
      endcase
      prog.push_back(HLT);
   endtask

   task automatic loadProgram();
      foreach (prog[i]) begin
         @(negedge CLOCK);
         progLoad.we = 1'b1;
         progLoad.addr = `ADDR_W'(i);
         progLoad.data = prog[i];
      end
      @(negedge CLOCK);
      progLoad = '0;
   endtask

   task automatic runProgram();
      seen = {};
      @(negedge CLOCK);
      exec = 1'b1;
      @(negedge CLOCK);
      exec = 1'b0;
      while (!halted) begin
         @(negedge CLOCK);
         if (outValid)
            seen.push_back(outData);
      end
      repeat (3) begin
         @(negedge CLOCK);
         if (outValid !== 1'b0) begin
            $display("outValid pulsed while the processor was halted");
            failCount++;
         end
      end
   endtask

   task automatic reportMismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] exp);
      $display("Mismatch %s: got %h expected %h", what, got, exp);
      mismatchCount++;
   endtask

   task automatic checkRow(input int idx, input int runNo, input caseRow_t r);
      if (seen.size() != int'(r.expOut)) begin
         $display("Row %0d run %0d: expected %0d output strobes but saw %0d",
                  idx, runNo, r.expOut, seen.size());
         failCount++;
      end
      else if (r.expOut && seen[0] !== r.expData)
         reportMismatch($sformatf("outData row %0d run %0d", idx, runNo), seen[0], r.expData);
      if (flags !== r.expFlags)
         reportMismatch($sformatf("flags row %0d run %0d", idx, runNo), {12'h0, flags},
                        {12'h0, r.expFlags});
   endtask

   initial begin
      rstN = 1'b0;
      exec = 1'b0;
      inData = '0;
      progLoad = '0;
      modelFlags = '0;
      fillTable();
      for (int i = 0; i < NUM_ROWS; i++) begin
         rows[i] = modelRow(rows[i]);
      end
      repeat (10) @(negedge CLOCK);
      rstN = 1'b1;
      @(negedge CLOCK);
      if (halted !== 1'b1)
         reportMismatch("halted after reset", 16'(halted), 16'h1);
      if (outValid !== 1'b0)
         reportMismatch("outValid after reset", 16'(outValid), 16'h0);
      if (flags !== 4'h0)
         reportMismatch("flags after reset", {12'h0, flags}, 16'h0);
      if (phase !== cpuPkg::PH_IDLE)
         reportMismatch("phase after reset", {13'h0, phase}, {13'h0, cpuPkg::PH_IDLE});
      for (int i = 0; i < NUM_ROWS; i++) begin
         buildProgram(rows[i]);
         loadProgram();
         inData = rows[i].inVal;
         runProgram();
         checkRow(i, 1, rows[i]);
         if (rows[i].rerun) begin
            runProgram(); // Restart from address 0
            checkRow(i, 2, rows[i]);
         end
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
      if (mismatchCount == 0 && failCount == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module simpleCpuTb -o simpleCpuSim -f sources.f

./obj_dir/simpleCpuSim | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Testbench reported errors, see sim.log"
   exit 1
fi
echo "Testbench finished without errors"

// ==== sources.f ====
+incdir+design
design/cpuPkg.sv
design/phaseSequencer.sv
design/programCounter.sv
design/controlUnit.sv
design/aluShifter.sv
design/registerFile.sv
design/unifiedMemory.sv
design/simpleCpu.sv
dv/simpleCpuTb.sv
